//--- project.f
perf_pkg.sv
cache_event_counter.sv
report_encoder.sv
byte_fifo.sv
uart_tx.sv
perf_uart_top.sv
perf_uart_checker.sv
tb_perf_uart.sv

//--- tb_perf_uart.sv
`timescale 1ns/100ps

module tb_perf_uart;

	import perf_pkg::*;

	localparam int CLKS_PER_BIT  = 8;
	localparam int NUM_REPORTS   = 5;
	localparam int REPORT_CYCLES = REPORT_LEN * 10 * CLKS_PER_BIT;
	localparam int STIM_CYCLES   = 25 + 400 + 300 + 200 + 8400 + 200 + 30 + NUM_REPORTS * 4;
	localparam int LIMIT_CYCLES  = (NUM_REPORTS * REPORT_CYCLES + STIM_CYCLES) * 12 / 10;

	logic               clk;
	logic               rstn;
	logic [NUM_EVT-1:0] evt_i;
	logic               cpu_done_i;
	logic               tx_o;
	logic               tx_busy_o;

	cnt_t               model_cnt [NUM_EVT];
	logic [7:0]         exp_q [$];
	logic [7:0]         rx_byte;
	int                 err_cnt;
	int                 timeout_cnt;
	int                 cycle_cnt;

	perf_uart_top #(.FIFO_DEPTH(16), .CLKS_PER_BIT(CLKS_PER_BIT)) dut (
		.clk(clk), .rstn(rstn), .evt_i(evt_i), .cpu_done_i(cpu_done_i),
		.tx_o(tx_o), .tx_busy_o(tx_busy_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			err_cnt++;
			$display("** Error: %s expected 0x%02h got 0x%02h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_cnt++;
			$display("** Error: %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
		end
	endtask

	// model counts each rise it drives
	task automatic drive_cycle(input logic [NUM_EVT-1:0] val, input logic done);
		@(negedge clk);
		for (int i = 0; i < NUM_EVT; i++) begin
			if (val[i] && !evt_i[i]) begin
				model_cnt[i]++;
			end
		end
		evt_i      = val;
		cpu_done_i = done;
	endtask

	function automatic void push_hex(input cnt_t val);
		string digits;
		digits = "0123456789ABCDEF";
		for (int k = 2; k >= 0; k--) begin
			exp_q.push_back(digits[val[k*4 +: 4]]);
		end
	endfunction

	function automatic void build_report();
		cnt_t l1d_sum;
		cnt_t l2_sum;
		l1d_sum = model_cnt[EV_L1D_READ] + model_cnt[EV_L1D_WRITE];
		l2_sum  = model_cnt[EV_L2_READ] + model_cnt[EV_L2_WRITE];
		exp_q.push_back(TAG_L1I);
		push_hex(model_cnt[EV_L1I_MISS]);
		push_hex(model_cnt[EV_L1I_READ]);
		exp_q.push_back(TAG_L1D);
		push_hex(model_cnt[EV_L1D_MISS]);
		push_hex(l1d_sum);
		exp_q.push_back(TAG_L2);
		push_hex(model_cnt[EV_L2_MISS]);
		push_hex(l2_sum);
	endfunction

	task automatic snapshot();
		drive_cycle('0, 1'b0);	// quiet lines around the rise
		drive_cycle('0, 1'b0);
		drive_cycle('0, 1'b1);
		build_report();
		drive_cycle('0, 1'b0);
	endtask

	task automatic random_traffic(input int n);
		logic [NUM_EVT-1:0] flip;
		for (int i = 0; i < n; i++) begin
			flip = NUM_EVT'($urandom()) & NUM_EVT'($urandom());	// pulses and levels
			drive_cycle(evt_i ^ flip, 1'b0);
		end
	endtask

	task automatic toggle_lines(input logic [NUM_EVT-1:0] mask, input int n);
		for (int i = 0; i < n; i++) begin
			drive_cycle((i % 2 == 0) ? mask : '0, 1'b0);
		end
	endtask

	task automatic wait_reports();
		while (exp_q.size() != 0 || tx_busy_o) begin
			@(negedge clk);
		end
	endtask

	task automatic finish_run();
		int chk_fails;
		chk_fails = dut.u_chk.fail_cnt;
		$display("errors: %0d, assertion failures: %0d, timeouts: %0d",
			err_cnt, chk_fails, timeout_cnt);
		if (err_cnt == 0 && chk_fails == 0 && timeout_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	// 8N1 decoder, sampling mid-bit
	initial begin
		@(posedge rstn);
		forever begin
			@(negedge clk);
			if (tx_o === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				compare_bit("tx_o", 1'b0, tx_o);
				compare_bit("tx_busy_o", 1'b1, tx_busy_o);
				for (int b = 0; b < 8; b++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					rx_byte[b] = tx_o;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (tx_o !== 1'b1) begin
					err_cnt++;
					$display("stop bit on tx_o was low at %0t", $time);
				end
				if (exp_q.size() == 0) begin
					err_cnt++;
					$display("frame on tx_o with no report expected at %0t", $time);
				end else begin
					compare_byte("tx_o", exp_q.pop_front(), rx_byte);
				end
			end
		end
	end

	initial begin
		while (cycle_cnt < LIMIT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		timeout_cnt++;
		$display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
		finish_run();
	end

	initial begin
		void'($urandom(76));
		rstn       = 1'b0;
		evt_i      = '0;
		cpu_done_i = 1'b0;
		for (int i = 0; i < NUM_EVT; i++) begin
			model_cnt[i] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		repeat (20) begin
			@(negedge clk);
			compare_bit("tx_o", 1'b1, tx_o);
			compare_bit("tx_busy_o", 1'b0, tx_busy_o);
		end
		random_traffic(400);
		snapshot();
		wait_reports();
		repeat (300) drive_cycle(NUM_EVT'(1) << EV_L2_MISS, 1'b0);	// held level
		toggle_lines(NUM_EVT'(1) << EV_L1D_READ, 200);
		snapshot();
		wait_reports();
		// 4200 rises, past the 12-bit wrap
		toggle_lines((NUM_EVT'(1) << EV_L1I_READ) | (NUM_EVT'(1) << EV_L1D_WRITE), 8400);
		snapshot();
		wait_reports();
		random_traffic(200);
		snapshot();
		random_traffic(30);
		snapshot();	// lands while the first report still fills the fifo
		wait_reports();
		finish_run();
	end

endmodule

//--- perf_uart_checker.sv
`timescale 1ns/100ps

module perf_uart_checker #(
	parameter int CLKS_PER_BIT = 868
) (
	input logic clk,
	input logic rstn,
	input logic wr_en_i,
	input logic full_i,
	input logic rd_en_i,
	input logic empty_i,
	input logic tx_i,
	input logic busy_i
);

	localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;

	int fail_cnt = 0;
	int since_pop;	// cycles since the last pop, saturating

	always_ff @(posedge clk) begin
		if (!rstn) begin
			since_pop <= FRAME_CLKS;
		end else if (rd_en_i) begin
			since_pop <= 0;
		end else if (since_pop < FRAME_CLKS) begin
			since_pop <= since_pop + 1;
		end
	end

	a_no_wr_full: assert property (@(posedge clk) disable iff (!rstn) !(wr_en_i && full_i))
		else begin
			$error("write presented while fifo full");
			fail_cnt++;
		end

	a_no_rd_empty: assert property (@(posedge clk) disable iff (!rstn) !(rd_en_i && empty_i))
		else begin
			$error("read presented while fifo empty");
			fail_cnt++;
		end

	// no frame in flight
	a_idle_high: assert property (@(posedge clk) disable iff (!rstn)
		(since_pop >= FRAME_CLKS) |-> (tx_i && !busy_i))
		else begin
			$error("serial line low or busy while transmitter idle");
			fail_cnt++;
		end

	a_no_pop_busy: assert property (@(posedge clk) disable iff (!rstn)
		rd_en_i |-> (since_pop >= FRAME_CLKS))
		else begin
			$error("pop before the previous frame ended");
			fail_cnt++;
		end

	a_start_after_pop: assert property (@(posedge clk) disable iff (!rstn)
		rd_en_i |=> (!tx_i && busy_i))
		else begin
			$error("start bit missing in the cycle after a pop");
			fail_cnt++;
		end

endmodule

bind perf_uart_top perf_uart_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_chk (
	.clk(clk), .rstn(rstn), .wr_en_i(wr_en), .full_i(full), .rd_en_i(rd_en),
	.empty_i(empty), .tx_i(tx_o), .busy_i(tx_busy_o)
);

//--- perf_uart_top.sv
`timescale 1ns/100ps

module perf_uart_top #(
	parameter int FIFO_DEPTH   = 32,
	parameter int CLKS_PER_BIT = 868
) (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [perf_pkg::NUM_EVT-1:0] evt_i,
	input  logic                         cpu_done_i,
	output logic                         tx_o,
	output logic                         tx_busy_o
);

	import perf_pkg::*;

	cnt_t       snap_l1i_read;
	cnt_t       snap_l1i_miss;
	cnt_t       snap_l1d_read;
	cnt_t       snap_l1d_write;
	cnt_t       snap_l1d_miss;
	cnt_t       snap_l2_read;
	cnt_t       snap_l2_write;
	cnt_t       snap_l2_miss;
	logic       snap_valid;
	logic       wr_en;
	logic [7:0] wr_data;
	logic       full;
	logic       rd_en;
	logic [7:0] rd_data;
	logic       empty;

	cache_event_counter u_counter (
		.clk(clk), .rstn(rstn), .evt_i(evt_i), .cpu_done_i(cpu_done_i),
		.snap_l1i_read_o(snap_l1i_read), .snap_l1i_miss_o(snap_l1i_miss),
		.snap_l1d_read_o(snap_l1d_read), .snap_l1d_write_o(snap_l1d_write),
		.snap_l1d_miss_o(snap_l1d_miss), .snap_l2_read_o(snap_l2_read),
		.snap_l2_write_o(snap_l2_write), .snap_l2_miss_o(snap_l2_miss),
		.snap_valid_o(snap_valid)
	);

	report_encoder u_encoder (
		.clk(clk), .rstn(rstn),
		.snap_l1i_read_i(snap_l1i_read), .snap_l1i_miss_i(snap_l1i_miss),
		.snap_l1d_read_i(snap_l1d_read), .snap_l1d_write_i(snap_l1d_write),
		.snap_l1d_miss_i(snap_l1d_miss), .snap_l2_read_i(snap_l2_read),
		.snap_l2_write_i(snap_l2_write), .snap_l2_miss_i(snap_l2_miss),
		.snap_valid_i(snap_valid), .full_i(full), .wr_en_o(wr_en), .wr_data_o(wr_data)
	);

	byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .rstn(rstn), .wr_en_i(wr_en), .wr_data_i(wr_data), .full_o(full),
		.rd_en_i(rd_en), .rd_data_o(rd_data), .empty_o(empty)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.clk(clk), .rstn(rstn), .empty_i(empty), .rd_data_i(rd_data),
		.rd_en_o(rd_en), .tx_o(tx_o), .busy_o(tx_busy_o)
	);

endmodule

//--- uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic       empty_i,
	input  logic [7:0] rd_data_i,
	output logic       rd_en_o,
	output logic       tx_o,
	output logic       busy_o
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

	tx_state_e  state;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_q;
	logic       bit_end;

	assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));
	assign rd_en_o = (state == TX_IDLE) && !empty_i;	// pop only when idle
	assign busy_o  = (state != TX_IDLE);

	always_comb begin
		case (state)
			TX_START: tx_o = 1'b0;
			TX_DATA:  tx_o = shift_q[0];	// lsb first
			default:  tx_o = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			clk_cnt <= (state == TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					if (rd_en_o) begin
						state   <= TX_START;
						bit_idx <= '0;
					end
				end
				TX_START: if (bit_end) state <= TX_DATA;
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= TX_STOP;
					end
				end
				default: if (bit_end) state <= TX_IDLE;	// stop bit done
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en_o) begin
			shift_q <= rd_data_i;
		end else if (state == TX_DATA && bit_end) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

endmodule

//--- byte_fifo.sv
`timescale 1ns/100ps

module byte_fifo #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic       wr_en_i,
	input  logic [7:0] wr_data_i,
	output logic       full_o,
	input  logic       rd_en_i,
	output logic [7:0] rd_data_o,
	output logic       empty_o
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [7:0]  mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr;	// extra msb tells full from empty
	logic [AW:0] rd_ptr;
	logic        do_wr;
	logic        do_rd;

	assign empty_o   = (wr_ptr == rd_ptr);
	assign full_o    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign do_wr     = wr_en_i && !full_o;
	assign do_rd     = rd_en_i && !empty_o;
	assign rd_data_o = mem[rd_ptr[AW-1:0]];	// show-ahead head byte

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr[AW-1:0]] <= wr_data_i;
		end
	end

endmodule

//--- report_encoder.sv
`timescale 1ns/100ps

module report_encoder (
	input  logic           clk,
	input  logic           rstn,
	input  perf_pkg::cnt_t snap_l1i_read_i,
	input  perf_pkg::cnt_t snap_l1i_miss_i,
	input  perf_pkg::cnt_t snap_l1d_read_i,
	input  perf_pkg::cnt_t snap_l1d_write_i,
	input  perf_pkg::cnt_t snap_l1d_miss_i,
	input  perf_pkg::cnt_t snap_l2_read_i,
	input  perf_pkg::cnt_t snap_l2_write_i,
	input  perf_pkg::cnt_t snap_l2_miss_i,
	input  logic           snap_valid_i,
	input  logic           full_i,
	output logic           wr_en_o,
	output logic [7:0]     wr_data_o
);

	import perf_pkg::*;

	localparam int NUM_SEC  = 3;
	localparam int SEC_DIGS = REPORT_LEN / NUM_SEC - 1;	// digits after each tag
	localparam int NUM_DIGS = SEC_DIGS / 2;	// digits per hex number

	typedef enum logic [1:0] {ENC_IDLE, ENC_TAG, ENC_DIGIT} enc_state_e;

	enc_state_e state;
	logic [1:0] sec_idx;
	logic [2:0] dig_idx;
	logic       pend_q;
	logic       last_byte;
	logic       start;
	cnt_t       miss_q [NUM_SEC];
	cnt_t       sum_q  [NUM_SEC];
	cnt_t       cur_val;
	logic [3:0] nib;

	function automatic logic [7:0] hex_ascii(input logic [3:0] n);
		return (n < 4'd10) ? 8'h30 + n : 8'h37 + n;	// 0-9, A-F
	endfunction

	assign last_byte = (state == ENC_DIGIT) && (dig_idx == 3'(SEC_DIGS - 1)) &&
		(sec_idx == 2'(NUM_SEC - 1));
	assign start   = (snap_valid_i || pend_q) && ((state == ENC_IDLE) || (wr_en_o && last_byte));
	assign wr_en_o = (state != ENC_IDLE) && !full_i;

	always_comb begin
		cur_val = (dig_idx < 3'(NUM_DIGS)) ? miss_q[sec_idx] : sum_q[sec_idx];
		case (dig_idx)
			3'd0, 3'd3: nib = cur_val[11:8];	// msb nibble first
			3'd1, 3'd4: nib = cur_val[7:4];
			default:    nib = cur_val[3:0];
		endcase
		if (state == ENC_TAG) begin
			case (sec_idx)
				2'd0:    wr_data_o = TAG_L1I;
				2'd1:    wr_data_o = TAG_L1D;
				default: wr_data_o = TAG_L2;
			endcase
		end else begin
			wr_data_o = hex_ascii(nib);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state   <= ENC_IDLE;
			sec_idx <= '0;
			dig_idx <= '0;
			pend_q  <= 1'b0;
		end else begin
			if (start) begin
				pend_q <= 1'b0;
			end else if (snap_valid_i) begin
				pend_q <= 1'b1;	// latest snapshot wins
			end
			if (start) begin
				state   <= ENC_TAG;
				sec_idx <= '0;
				dig_idx <= '0;
			end else if (wr_en_o) begin
				case (state)
					ENC_TAG: begin
						state   <= ENC_DIGIT;
						dig_idx <= '0;
					end
					ENC_DIGIT: begin
						if (dig_idx == 3'(SEC_DIGS - 1)) begin
							dig_idx <= '0;
							if (last_byte) begin
								state <= ENC_IDLE;
							end else begin
								sec_idx <= sec_idx + 1'b1;
								state   <= ENC_TAG;
							end
						end else begin
							dig_idx <= dig_idx + 1'b1;
						end
					end
					default: state <= ENC_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			miss_q[0] <= snap_l1i_miss_i;
			sum_q[0]  <= snap_l1i_read_i;
			miss_q[1] <= snap_l1d_miss_i;
			sum_q[1]  <= snap_l1d_read_i + snap_l1d_write_i;	// wraps to 12 bits
			miss_q[2] <= snap_l2_miss_i;
			sum_q[2]  <= snap_l2_read_i + snap_l2_write_i;
		end
	end

endmodule

//--- cache_event_counter.sv
`timescale 1ns/100ps

module cache_event_counter (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [perf_pkg::NUM_EVT-1:0] evt_i,
	input  logic                         cpu_done_i,
	output perf_pkg::cnt_t               snap_l1i_read_o,
	output perf_pkg::cnt_t               snap_l1i_miss_o,
	output perf_pkg::cnt_t               snap_l1d_read_o,
	output perf_pkg::cnt_t               snap_l1d_write_o,
	output perf_pkg::cnt_t               snap_l1d_miss_o,
	output perf_pkg::cnt_t               snap_l2_read_o,
	output perf_pkg::cnt_t               snap_l2_write_o,
	output perf_pkg::cnt_t               snap_l2_miss_o,
	output logic                         snap_valid_o
);

	import perf_pkg::*;

	logic [NUM_EVT-1:0] evt_prev;
	logic [NUM_EVT-1:0] evt_rise;
	logic               done_prev;
	logic               done_rise;
	cnt_t               cnt [NUM_EVT];

	assign evt_rise  = evt_i & ~evt_prev;	// level held high counts once
	assign done_rise = cpu_done_i & ~done_prev;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			evt_prev     <= '0;
			done_prev    <= 1'b0;
			snap_valid_o <= 1'b0;
			for (int i = 0; i < NUM_EVT; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			evt_prev     <= evt_i;
			done_prev    <= cpu_done_i;
			snap_valid_o <= done_rise;	// one cycle after the freeze
			for (int i = 0; i < NUM_EVT; i++) begin
				if (evt_rise[i]) begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	// values before this cycle's increments are frozen
	always_ff @(posedge clk) begin
		if (done_rise) begin
			snap_l1i_read_o  <= cnt[EV_L1I_READ];
			snap_l1i_miss_o  <= cnt[EV_L1I_MISS];
			snap_l1d_read_o  <= cnt[EV_L1D_READ];
			snap_l1d_write_o <= cnt[EV_L1D_WRITE];
			snap_l1d_miss_o  <= cnt[EV_L1D_MISS];
			snap_l2_read_o   <= cnt[EV_L2_READ];
			snap_l2_write_o  <= cnt[EV_L2_WRITE];
			snap_l2_miss_o   <= cnt[EV_L2_MISS];
		end
	end

endmodule

//--- perf_pkg.sv
package perf_pkg;

	typedef logic [11:0] cnt_t;	// free running, wraps at 4096

	localparam int NUM_EVT = 8;

	// bit positions on the event bus
	typedef enum int unsigned {
		EV_L1I_READ  = 0,
		EV_L1I_MISS  = 1,
		EV_L1D_READ  = 2,
		EV_L1D_WRITE = 3,
		EV_L1D_MISS  = 4,
		EV_L2_READ   = 5,
		EV_L2_WRITE  = 6,
		EV_L2_MISS   = 7
	} evt_e;

	// three sections of tag + 3 miss digits + 3 access digits
	localparam int REPORT_LEN = 21;

	localparam logic [7:0] TAG_L1I = 8'h61;	// a
	localparam logic [7:0] TAG_L1D = 8'h62;	// b
	localparam logic [7:0] TAG_L2  = 8'h63;	// c

endpackage
